// ==== common/xadc_config.svh ====
`ifndef XADC_CONFIG_SVH
`define XADC_CONFIG_SVH

////////////////////
// Packet geometry
////////////////////

// Five 12-bit results share one 64-bit packet
`define SAMPLES_PER_PACKET 5

// 16-bit FIFO words per packet
`define WORDS_PER_PACKET 4

////////////////////
// Frame and VMM limits
////////////////////

`define MAX_FRAME_WORDS 600   // Upper bound of one UDP frame
`define VMM_LAST 7            // Highest VMM number

`endif

// ==== common/xadc_pkg.sv ====
package xadc_pkg;

    typedef logic [11:0] adc_result_t;   // One ADC conversion
    typedef logic [4:0]  adc_channel_t;
    typedef logic [2:0]  vmm_sel_t;
    typedef logic [3:0]  vmm_id_t;       // 8 to 15 selects every VMM
    typedef logic [10:0] sample_cnt_t;
    typedef logic [17:0] delay_cnt_t;
    typedef logic [63:0] packet_t;       // Header nibble plus five results
    typedef logic [15:0] fifo_word_t;
    typedef logic [11:0] frame_len_t;    // Counted in 16-bit words

    ////////////////////
    // State machines
    ////////////////////

    typedef enum logic [2:0] {
        seq_idle, seq_start, seq_wait_sample, seq_delay, seq_wait_burst, seq_finish
    } seq_state_t;

    typedef enum logic [1:0] {
        chan_idle, chan_select, chan_wait, chan_report
    } chan_state_t;

    typedef enum logic [2:0] {
        wr_idle, wr_load, wr_send, wr_last, wr_gap, wr_hold
    } wr_state_t;

endpackage

// ==== design/channel_reader.sv ====
module channel_reader
(
    input  logic                   clk125,
    input  logic                   rst,
    input  logic                   sample_start,
    input  xadc_pkg::vmm_sel_t     vmm_sel,
    input  logic                   adc_done,
    input  xadc_pkg::adc_result_t  adc_result,
    output logic                   adc_start,
    output xadc_pkg::adc_channel_t adc_channel,
    output logic                   result_valid,
    output xadc_pkg::adc_result_t  result,
    output logic                   sample_done
);

    xadc_pkg::chan_state_t state;

    // Conversion result, valid with result_valid
    always_ff @(posedge clk125)
    begin
        if (state == xadc_pkg::chan_wait && adc_done)
            result <= adc_result;
    end

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state        <= xadc_pkg::chan_idle;
            adc_channel  <= '0;
            adc_start    <= 1'b0;
            result_valid <= 1'b0;
            sample_done  <= 1'b0;
        end
        else
        begin
            adc_start    <= 1'b0;
            result_valid <= 1'b0;
            sample_done  <= 1'b0;
            case (state)
                xadc_pkg::chan_idle:
                begin
                    if (sample_start)
                    begin
                        adc_channel <= {2'b00, vmm_sel};   // One channel per VMM
                        state       <= xadc_pkg::chan_select;
                    end
                end

                xadc_pkg::chan_select:
                begin
                    adc_start <= 1'b1;
                    state     <= xadc_pkg::chan_wait;
                end

                xadc_pkg::chan_wait:
                    if (adc_done)
                    begin
                        result_valid <= 1'b1;
                        state        <= xadc_pkg::chan_report;
                    end

                xadc_pkg::chan_report:
                begin
                    sample_done <= 1'b1;
                    state       <= xadc_pkg::chan_idle;
                end

                default: state <= xadc_pkg::chan_idle;
            endcase
        end
    end

endmodule

// ==== design/xadc_sequencer.sv ====
`include "xadc_config.svh"

module xadc_sequencer
(
    input  logic                  clk125,
    input  logic                  rst,
    input  logic                  data_in_rdy,
    input  xadc_pkg::vmm_id_t     vmm_id,
    input  xadc_pkg::sample_cnt_t sample_size,
    input  xadc_pkg::delay_cnt_t  delay_in,
    input  logic                  udp_done,
    input  logic                  sample_done,
    input  logic                  burst_done,
    output logic                  sample_start,
    output xadc_pkg::vmm_sel_t    vmm_sel,
    output logic                  sample_last,
    output logic                  xadc_busy
);

    xadc_pkg::seq_state_t  state;
    xadc_pkg::sample_cnt_t sample_cnt;
    xadc_pkg::sample_cnt_t sample_cnt_next;
    xadc_pkg::sample_cnt_t size_r;       // Latched sample_size
    xadc_pkg::delay_cnt_t  delay_r;      // Latched delay_in
    xadc_pkg::delay_cnt_t  delay_cnt;
    logic                  all_vmm;      // Command asked for every VMM

    assign sample_cnt_next = sample_cnt + 1'b1;

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state        <= xadc_pkg::seq_idle;
            sample_cnt   <= '0;
            delay_cnt    <= '0;
            size_r       <= '0;
            delay_r      <= '0;
            all_vmm      <= 1'b0;
            vmm_sel      <= '0;
            sample_start <= 1'b0;
            sample_last  <= 1'b0;
            xadc_busy    <= 1'b0;
        end
        else
        begin
            sample_start <= 1'b0;
            case (state)
                xadc_pkg::seq_idle:
                begin
                    if (data_in_rdy)
                    begin
                        // Take the command as it stands now
                        all_vmm    <= vmm_id[3];
                        vmm_sel    <= vmm_id[3] ? '0 : vmm_id[2:0];
                        size_r     <= sample_size;
                        delay_r    <= delay_in;
                        sample_cnt <= '0;
                        xadc_busy  <= 1'b1;
                        state      <= xadc_pkg::seq_start;
                    end
                end

                xadc_pkg::seq_start:
                begin
                    sample_start <= 1'b1;
                    sample_cnt   <= sample_cnt_next;
                    sample_last  <= (sample_cnt_next == size_r);
                    state        <= xadc_pkg::seq_wait_sample;
                end

                xadc_pkg::seq_wait_sample:
                begin
                    if (sample_done)
                    begin
                        if (sample_last)
                            state <= xadc_pkg::seq_wait_burst;
                        else if (delay_r == '0)
                            state <= xadc_pkg::seq_start;   // Back to back
                        else
                        begin
                            delay_cnt <= xadc_pkg::delay_cnt_t'(1);
                            state     <= xadc_pkg::seq_delay;
                        end
                    end
                end

                // Idle cycles between conversions
                xadc_pkg::seq_delay:
                begin
                    if (delay_cnt == delay_r)
                        state <= xadc_pkg::seq_start;
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end

                xadc_pkg::seq_wait_burst:
                begin
                    if (burst_done)
                    begin
                        sample_cnt <= '0;
                        if (all_vmm && vmm_sel != xadc_pkg::vmm_sel_t'(`VMM_LAST))
                        begin
                            vmm_sel <= vmm_sel + 1'b1;   // Next VMM in turn
                            state   <= xadc_pkg::seq_start;
                        end
                        else
                            state <= xadc_pkg::seq_finish;
                    end
                end

                // Hold busy until the host drops the command and the frame is out
                xadc_pkg::seq_finish:
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= xadc_pkg::seq_idle;
                    end
                end

                default: state <= xadc_pkg::seq_idle;
            endcase
        end
    end

endmodule

// ==== packer/packet_builder.sv ====
`include "xadc_config.svh"

module packet_builder
(
    input  logic                  clk125,
    input  logic                  rst,
    input  logic                  result_valid,
    input  xadc_pkg::adc_result_t result,
    input  xadc_pkg::vmm_sel_t    vmm_sel,
    input  logic                  sample_last,
    input  logic                  packet_taken,
    output logic                  packet_ready,
    output xadc_pkg::packet_t     packet,
    output logic                  packet_last
);

    logic [2:0] slot;        // Next free 12-bit slot
    logic       close_pkt;

    // Full packet or final sample of the burst
    assign close_pkt = (slot == 3'(`SAMPLES_PER_PACKET - 1)) || sample_last;

    ////////////////////
    // Slot filling
    ////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            slot         <= '0;
            packet       <= '0;
            packet_ready <= 1'b0;
            packet_last  <= 1'b0;
        end
        else
        begin
            packet_ready <= 1'b0;

            // Writer is done with it, start from an empty packet
            if (packet_taken)
            begin
                packet      <= '0;
                packet_last <= 1'b0;
            end

            if (result_valid)
            begin
                packet[63:60]         <= {1'b0, vmm_sel};   // Header nibble
                packet[slot * 12 +: 12] <= result;
                if (close_pkt)
                begin
                    slot         <= '0;
                    packet_ready <= 1'b1;
                    packet_last  <= sample_last;
                end
                else
                    slot <= slot + 1'b1;
            end
        end
    end

endmodule

// ==== packer/fifo_writer.sv ====
`include "xadc_config.svh"

module fifo_writer
(
    input  logic                 clk125,
    input  logic                 rst,
    input  logic                 packet_ready,
    input  xadc_pkg::packet_t    packet,
    input  logic                 packet_last,
    output xadc_pkg::fifo_word_t fifo_bus,
    output logic                 data_fifo_enable,
    output xadc_pkg::frame_len_t packet_len,
    output logic                 end_of_data,
    output logic                 packet_taken,
    output logic                 burst_done
);

    xadc_pkg::wr_state_t  state;
    xadc_pkg::frame_len_t frame_len;   // Words in the current frame
    logic [1:0]           word_idx;    // Next word, 0 is the top one

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state            <= xadc_pkg::wr_idle;
            frame_len        <= '0;
            word_idx         <= '0;
            fifo_bus         <= '0;
            data_fifo_enable <= 1'b0;
            packet_len       <= '0;
            end_of_data      <= 1'b0;
            packet_taken     <= 1'b0;
            burst_done       <= 1'b0;
        end
        else
        begin
            packet_taken <= 1'b0;
            burst_done   <= 1'b0;
            case (state)
                xadc_pkg::wr_idle:
                    if (packet_ready)
                    begin
                        frame_len <= frame_len + xadc_pkg::frame_len_t'(`WORDS_PER_PACKET);
                        state     <= xadc_pkg::wr_load;
                    end

                xadc_pkg::wr_load:
                begin
                    packet_len       <= frame_len;
                    fifo_bus         <= packet[63:48];   // MSW first
                    data_fifo_enable <= 1'b1;
                    word_idx         <= 2'd1;
                    state            <= xadc_pkg::wr_send;
                end

                xadc_pkg::wr_send:
                begin
                    fifo_bus <= packet[(`WORDS_PER_PACKET - 1 - word_idx) * 16 +: 16];
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == 2'(`WORDS_PER_PACKET - 1))
                    begin
                        // Frame closes on burst end or when full
                        end_of_data <= packet_last ||
                                       (frame_len >= xadc_pkg::frame_len_t'(`MAX_FRAME_WORDS));
                        state       <= xadc_pkg::wr_last;
                    end
                end

                ////////////////////
                // Wrap up
                ////////////////////

                xadc_pkg::wr_last:
                begin
                    data_fifo_enable <= 1'b0;
                    end_of_data      <= 1'b0;
                    packet_taken     <= 1'b1;
                    burst_done       <= packet_last;
                    if (end_of_data)
                        frame_len <= '0;   // New frame starts
                    state <= xadc_pkg::wr_gap;
                end

                xadc_pkg::wr_gap:  state <= xadc_pkg::wr_hold;
                xadc_pkg::wr_hold: state <= xadc_pkg::wr_idle;

                default: state <= xadc_pkg::wr_idle;
            endcase
        end
    end

endmodule

// ==== design/xadc_readout_top.sv ====
module xadc_readout_top
(
    input  logic                   clk125,
    input  logic                   rst,
    input  logic                   data_in_rdy,
    input  xadc_pkg::vmm_id_t      vmm_id,
    input  xadc_pkg::sample_cnt_t  sample_size,
    input  xadc_pkg::delay_cnt_t   delay_in,
    input  logic                   udp_done,
    input  logic                   adc_done,
    input  xadc_pkg::adc_result_t  adc_result,
    output logic                   adc_start,
    output xadc_pkg::adc_channel_t adc_channel,
    output xadc_pkg::fifo_word_t   fifo_bus,
    output logic                   data_fifo_enable,
    output xadc_pkg::frame_len_t   packet_len,
    output logic                   end_of_data,
    output logic                   xadc_busy
);

    logic                  sample_start;
    logic                  sample_last;
    logic                  sample_done;
    xadc_pkg::vmm_sel_t    vmm_sel;
    logic                  result_valid;
    xadc_pkg::adc_result_t result;
    logic                  packet_ready;
    logic                  packet_last;
    logic                  packet_taken;
    xadc_pkg::packet_t     packet;
    logic                  burst_done;

    // Command handling and VMM iteration
    xadc_sequencer u_seq
    (
        .clk125      (clk125),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .sample_done (sample_done),
        .burst_done  (burst_done),
        .sample_start(sample_start),
        .vmm_sel     (vmm_sel),
        .sample_last (sample_last),
        .xadc_busy   (xadc_busy)
    );

    channel_reader u_chan
    (
        .clk125      (clk125),
        .rst         (rst),
        .sample_start(sample_start),
        .vmm_sel     (vmm_sel),
        .adc_done    (adc_done),
        .adc_result  (adc_result),
        .adc_start   (adc_start),
        .adc_channel (adc_channel),
        .result_valid(result_valid),
        .result      (result),
        .sample_done (sample_done)
    );

    ////////////////////
    // Packer
    ////////////////////

    packet_builder u_pkt
    (
        .clk125      (clk125),
        .rst         (rst),
        .result_valid(result_valid),
        .result      (result),
        .vmm_sel     (vmm_sel),
        .sample_last (sample_last),
        .packet_taken(packet_taken),
        .packet_ready(packet_ready),
        .packet      (packet),
        .packet_last (packet_last)
    );

    fifo_writer u_wr
    (
        .clk125          (clk125),
        .rst             (rst),
        .packet_ready    (packet_ready),
        .packet          (packet),
        .packet_last     (packet_last),
        .fifo_bus        (fifo_bus),
        .data_fifo_enable(data_fifo_enable),
        .packet_len      (packet_len),
        .end_of_data     (end_of_data),
        .packet_taken    (packet_taken),
        .burst_done      (burst_done)
    );

endmodule

// ==== verification/tb_xadc_readout.sv ====
`include "xadc_config.svh"

module tb_xadc_readout;

    logic                   clk125;
    logic                   rst;
    logic                   data_in_rdy;
    xadc_pkg::vmm_id_t      vmm_id;
    xadc_pkg::sample_cnt_t  sample_size;
    xadc_pkg::delay_cnt_t   delay_in;
    logic                   udp_done;
    logic                   adc_done;
    xadc_pkg::adc_result_t  adc_result;
    logic                   adc_start;
    xadc_pkg::adc_channel_t adc_channel;
    xadc_pkg::fifo_word_t   fifo_bus;
    logic                   data_fifo_enable;
    xadc_pkg::frame_len_t   packet_len;
    logic                   end_of_data;
    logic                   xadc_busy;

    // Seen by the ADC responder and the FIFO monitor
    logic [4:0]  chan_q[$];
    logic [11:0] res_q[$];
    logic [15:0] word_q[$];
    logic [11:0] len_q[$];
    logic        eod_q[$];
    int          error_count = 0;

    xadc_readout_top dut0
    (
        .clk125          (clk125),
        .rst             (rst),
        .data_in_rdy     (data_in_rdy),
        .vmm_id          (vmm_id),
        .sample_size     (sample_size),
        .delay_in        (delay_in),
        .udp_done        (udp_done),
        .adc_done        (adc_done),
        .adc_result      (adc_result),
        .adc_start       (adc_start),
        .adc_channel     (adc_channel),
        .fifo_bus        (fifo_bus),
        .data_fifo_enable(data_fifo_enable),
        .packet_len      (packet_len),
        .end_of_data     (end_of_data),
        .xadc_busy       (xadc_busy)
    );

    initial
    begin
        clk125 = 1'b0;
        forever #2 clk125 = ~clk125;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    ////////////////////
    // ADC and FIFO side
    ////////////////////

    // Answers each conversion after 20 to 40 cycles
    task automatic respond_adc();
        int lat;
        forever
        begin
            @(negedge clk125);
            if (adc_start)
            begin
                chan_q.push_back(adc_channel);
                lat = 20 + $urandom_range(20);
                repeat (lat - 1)
                begin
                    @(negedge clk125);
                    compare_value("adc_start during conversion", 0, adc_start);
                end
                adc_result = 12'($urandom);
                adc_done   = 1'b1;
                res_q.push_back(adc_result);
                @(negedge clk125);
                adc_done = 1'b0;
            end
        end
    endtask

    task automatic monitor_fifo();
        forever
        begin
            @(negedge clk125);
            if (data_fifo_enable)
            begin
                word_q.push_back(fifo_bus);
                len_q.push_back(packet_len);
                eod_q.push_back(end_of_data);
            end
            else
                compare_value("end_of_data outside a word", 0, end_of_data);
        end
    endtask

    task automatic watch_timeout(input longint cycles);
        repeat (cycles) @(posedge clk125);
        $display("Timeout: the readout did not finish within %0d cycles", cycles);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation timed out");
    endtask

    // Reference packing of the recorded conversions
    task automatic check_command(input string name, input int vmm_first,
                                 input int vmm_count, input int size);
        logic [63:0] pkt;
        logic        eod;
        int          slot;
        int          k;
        int          n;
        int          fl;
        int          v;
        compare_value({name, " conversions"}, vmm_count * size, chan_q.size());
        compare_value({name, " word count"}, vmm_count * ((size + 4) / 5) * 4, word_q.size());
        n  = 0;
        k  = 0;
        fl = 0;
        for (int b = 0; b < vmm_count; b++)
        begin
            v    = vmm_first + b;
            slot = 0;
            pkt  = '0;
            for (int i = 0; i < size; i++)
            begin
                compare_value($sformatf("%s channel %0d", name, n), v, chan_q[n]);
                pkt[63:60]          = 4'(v);   // VMM header
                pkt[slot * 12 +: 12] = res_q[n];
                n++;
                if (slot == `SAMPLES_PER_PACKET - 1 || i == size - 1)
                begin
                    fl += `WORDS_PER_PACKET;
                    eod = (i == size - 1) || (fl >= `MAX_FRAME_WORDS);
                    for (int w = 0; w < `WORDS_PER_PACKET; w++)
                    begin
                        compare_value($sformatf("%s word %0d", name, k),
                                      pkt[63 - 16 * w -: 16], word_q[k]);
                        compare_value($sformatf("%s packet_len %0d", name, k), fl, len_q[k]);
                        compare_value($sformatf("%s end_of_data %0d", name, k),
                                      (w == `WORDS_PER_PACKET - 1) && eod, eod_q[k]);
                        k++;
                    end
                    if (eod)
                        fl = 0;   // Next frame
                    pkt  = '0;
                    slot = 0;
                end
                else
                    slot++;
            end
        end
    endtask

    task automatic run_command(input string name, input logic [3:0] id,
                               input int size, input int delay);
        int vmm_first;
        int vmm_count;
        int n_words;
        int wait_cnt;
        vmm_first = id[3] ? 0 : int'(id[2:0]);
        vmm_count = id[3] ? 8 : 1;
        n_words   = vmm_count * ((size + 4) / 5) * 4;
        chan_q.delete();
        res_q.delete();
        word_q.delete();
        len_q.delete();
        eod_q.delete();
        @(negedge clk125);
        vmm_id      = id;
        sample_size = 11'(size);
        delay_in    = 18'(delay);
        data_in_rdy = 1'b1;
        udp_done    = 1'b0;
        while (!xadc_busy)
            @(negedge clk125);
        while (word_q.size() < n_words)
            @(negedge clk125);
        repeat (10) @(negedge clk125);
        udp_done = 1'b1;   // Frame out, command still held
        repeat (10) @(negedge clk125);
        compare_value({name, " busy while command held"}, 1, xadc_busy);
        data_in_rdy = 1'b0;
        udp_done    = 1'b0;
        repeat (10) @(negedge clk125);
        compare_value({name, " busy before udp_done"}, 1, xadc_busy);
        udp_done = 1'b1;
        wait_cnt = 0;
        while (xadc_busy && wait_cnt < 4)
        begin
            @(negedge clk125);
            wait_cnt++;
        end
        compare_value({name, " busy released"}, 0, xadc_busy);
        udp_done = 1'b0;
        check_command(name, vmm_first, vmm_count, size);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        string      names[7];
        logic [3:0] ids[7];
        int         sizes[7];
        int         delays[7];
        longint     limit;
        void'($urandom(51961));
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b0;
        adc_done    = 1'b0;
        adc_result  = '0;

        names[0] = "single_vmm";
        ids[0]   = 4'($urandom_range(7));
        sizes[0] = 7;                        // Two packets, second one partial
        delays[0] = $urandom_range(20);
        names[1] = "all_vmm";
        ids[1]   = 4'd12;
        sizes[1] = 1 + $urandom_range(11);
        delays[1] = $urandom_range(15);
        names[2] = "long_burst";
        ids[2]   = 4'($urandom_range(7));
        sizes[2] = 800;                      // Crosses the frame limit
        delays[2] = 0;
        for (int i = 3; i < 7; i++)
        begin
            names[i]  = $sformatf("random_%0d", i - 3);
            ids[i]    = 4'($urandom_range(15));
            sizes[i]  = 1 + $urandom_range(29);
            delays[i] = $urandom_range(30);
        end

        limit = 1000;
        for (int i = 0; i < 7; i++)
            limit += (ids[i][3] ? 8 : 1) * sizes[i] * (200 + delays[i]);

        fork
            watch_timeout(limit);
            respond_adc();
            monitor_fifo();
        join_none

        repeat (16) @(negedge clk125);
        rst = 1'b0;
        repeat (4) @(negedge clk125);

        for (int i = 0; i < 7; i++)
            run_command(names[i], ids[i], sizes[i], delays[i]);

        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/xadc_pkg.sv
design/channel_reader.sv
design/xadc_sequencer.sv
packer/packet_builder.sv
packer/fifo_writer.sv
design/xadc_readout_top.sv
verification/tb_xadc_readout.sv

// ==== Bender.yml ====
package:
  name: xadc_readout

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/xadc_pkg.sv
      - design/channel_reader.sv
      - design/xadc_sequencer.sv
      - packer/packet_builder.sv
      - packer/fifo_writer.sv
      - design/xadc_readout_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_xadc_readout.sv
